/* design/alu_unit.sv */
`timescale 1ns/10ps

module alu_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          iss_valid,
    input  ooo_pkg::opcode_t              iss_op,
    input  logic [ooo_pkg::rob_tag_w-1:0] iss_tag,
    input  logic [31:0]                   iss_a,
    input  logic [31:0]                   iss_b,
    output logic                          cdb_valid,
    output logic [ooo_pkg::rob_tag_w-1:0] cdb_tag,
    output logic [31:0]                   cdb_data
);
    import ooo_pkg::*;

    logic [31:0] result;

    // all operations wrap at 32 bits
    always_comb begin
        case (iss_op)
            op_add, op_addi: result = iss_a + iss_b;
            op_sub:          result = iss_a - iss_b;
            op_and:          result = iss_a & iss_b;
            op_or:           result = iss_a | iss_b;
            op_xor:          result = iss_a ^ iss_b;
            op_slt:          result = {31'd0, $signed(iss_a) < $signed(iss_b)};
            op_sll:          result = iss_a << iss_b[4:0];
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag  <= iss_tag;
        cdb_data <= result;
    end

endmodule

/* design/inst_queue.sv */
`timescale 1ns/10ps

module inst_queue (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           run,
    input  logic                           halted,
    input  logic [31:0]                    fetch_data,
    input  logic                           disp_take,
    output logic [ooo_pkg::prog_adr_w-1:0] fetch_adr,
    output logic                           iq_valid,
    output ooo_pkg::opcode_t               iq_op,
    output logic [ooo_pkg::reg_idx_w-1:0]  iq_rd,
    output logic [ooo_pkg::reg_idx_w-1:0]  iq_rs,
    output logic [ooo_pkg::reg_idx_w-1:0]  iq_rt,
    output logic [31:0]                    iq_imm
);
    import ooo_pkg::*;

    opcode_t fetch_op;
    logic    halt_seen;
    logic    load;

    assign fetch_op = opcode_t'(fetch_data[op_hi:op_lo]);

    // refill when empty or when the held instruction leaves this cycle
    assign load = run && !halted && !halt_seen && (!iq_valid || disp_take);

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_adr <= '0;
            iq_valid  <= 1'b0;
            halt_seen <= 1'b0;
        end else if (load) begin
            fetch_adr <= fetch_adr + 1'b1;
            iq_valid  <= 1'b1;
            // nothing is fetched past a halt
            halt_seen <= (fetch_op == op_hlt);
        end else if (disp_take) begin
            iq_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            iq_op  <= fetch_op;
            iq_rd  <= fetch_data[rd_hi:rd_lo];
            iq_rs  <= fetch_data[rs_hi:rs_lo];
            iq_rt  <= fetch_data[rt_hi:rt_lo];
            iq_imm <= {{(32 - imm_w){fetch_data[imm_w-1]}}, fetch_data[imm_w-1:0]};
        end
    end

endmodule

/* design/ooo_pkg.sv */
package ooo_pkg;

    // opcode lives in instruction bits 31:28
    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_xor  = 4'h5,
        op_slt  = 4'h6,
        op_sll  = 4'h7,
        op_addi = 4'h8,
        op_hlt  = 4'hf
    } opcode_t;

    // instruction field positions
    localparam int op_hi = 31;
    localparam int op_lo = 28;
    localparam int rd_hi = 25;
    localparam int rd_lo = 21;
    localparam int rs_hi = 20;
    localparam int rs_lo = 16;
    localparam int rt_hi = 15;
    localparam int rt_lo = 11;
    localparam int imm_w = 16;

    // tag widths follow from these sizes
    localparam int num_regs   = 32;
    localparam int reg_idx_w  = 5;
    localparam int rob_depth  = 8;
    localparam int rob_tag_w  = 3;
    localparam int rs_depth   = 4;
    localparam int rs_idx_w   = 2;
    localparam int prog_depth = 64;
    localparam int prog_adr_w = 6;

    // program space sits at the bottom of the wishbone word addresses
    localparam int wb_adr_w = 9;
    localparam logic [wb_adr_w-1:0] ctrl_adr = 9'h100;

endpackage

/* design/prog_mem_wb.sv */
`timescale 1ns/10ps

module prog_mem_wb (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [ooo_pkg::wb_adr_w-1:0]   wb_adr,
    input  logic [31:0]                    wb_dat_w,
    input  logic [ooo_pkg::prog_adr_w-1:0] fetch_adr,
    input  logic                           halted,
    output logic [31:0]                    wb_dat_r,
    output logic                           wb_ack,
    output logic                           run,
    output logic [31:0]                    fetch_data
);
    import ooo_pkg::*;

    logic [31:0] mem [prog_depth];
    logic        req;
    logic        is_ctrl;
    logic        is_prog;

    // new access only while no ack is pending
    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign is_ctrl = (wb_adr == ctrl_adr);
    assign is_prog = (wb_adr[wb_adr_w-1:prog_adr_w] == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            run    <= 1'b0;
        end else begin
            wb_ack <= req;
            if (req && wb_we && is_ctrl && wb_dat_w[0]) begin
                run <= 1'b1;
            end
        end
    end

    // program loading locked out once running
    always_ff @(posedge clk) begin
        if (req && wb_we && is_prog && !run) begin
            mem[wb_adr[prog_adr_w-1:0]] <= wb_dat_w;
        end
        if (req && !wb_we) begin
            wb_dat_r <= is_ctrl ? {31'd0, halted} : mem[wb_adr[prog_adr_w-1:0]];
        end
    end

    assign fetch_data = mem[fetch_adr];

endmodule

/* design/reg_status_file.sv */
`timescale 1ns/10ps

module reg_status_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [ooo_pkg::reg_idx_w-1:0] rd_idx1,
    input  logic [ooo_pkg::reg_idx_w-1:0] rd_idx2,
    input  logic                          tag_we,
    input  logic [ooo_pkg::reg_idx_w-1:0] tag_idx,
    input  logic [ooo_pkg::rob_tag_w-1:0] tag_val,
    input  logic                          commit_valid,
    input  logic [ooo_pkg::reg_idx_w-1:0] commit_rd,
    input  logic [ooo_pkg::rob_tag_w-1:0] commit_tag,
    input  logic [31:0]                   commit_data,
    output logic [31:0]                   val1,
    output logic [31:0]                   val2,
    output logic                          busy1,
    output logic                          busy2,
    output logic [ooo_pkg::rob_tag_w-1:0] tag1,
    output logic [ooo_pkg::rob_tag_w-1:0] tag2
);
    import ooo_pkg::*;

    logic [31:0]          regs [num_regs];
    logic [rob_tag_w-1:0] tags [num_regs];
    logic [num_regs-1:0]  busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_rd != '0) begin
                regs[commit_rd] <= commit_data;
                // a younger writer may already own the register
                if (tags[commit_rd] == commit_tag) begin
                    busy[commit_rd] <= 1'b0;
                end
            end
            // rename wins over a release in the same cycle
            if (tag_we && tag_idx != '0) begin
                busy[tag_idx] <= 1'b1;
                tags[tag_idx] <= tag_val;
            end
        end
    end

    // r0 is never tagged and always reads zero
    assign val1  = (rd_idx1 == '0) ? '0 : regs[rd_idx1];
    assign val2  = (rd_idx2 == '0) ? '0 : regs[rd_idx2];
    assign busy1 = busy[rd_idx1];
    assign busy2 = busy[rd_idx2];
    assign tag1  = tags[rd_idx1];
    assign tag2  = tags[rd_idx2];

endmodule

/* design/reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alloc,
    input  ooo_pkg::opcode_t              alloc_op,
    input  logic [ooo_pkg::reg_idx_w-1:0] alloc_rd,
    input  logic                          cdb_valid,
    input  logic [ooo_pkg::rob_tag_w-1:0] cdb_tag,
    input  logic [31:0]                   cdb_data,
    input  logic [ooo_pkg::rob_tag_w-1:0] rp_tag1,
    input  logic [ooo_pkg::rob_tag_w-1:0] rp_tag2,
    output logic                          full,
    output logic [ooo_pkg::rob_tag_w-1:0] tail_tag,
    output logic                          rp_ready1,
    output logic                          rp_ready2,
    output logic [31:0]                   rp_data1,
    output logic [31:0]                   rp_data2,
    output logic                          commit_valid,
    output logic [ooo_pkg::reg_idx_w-1:0] commit_rd,
    output logic [31:0]                   commit_data,
    output logic [ooo_pkg::rob_tag_w-1:0] commit_tag,
    output logic                          halted
);
    import ooo_pkg::*;

    logic [rob_tag_w-1:0] head;
    logic [rob_tag_w-1:0] tail;
    logic [rob_tag_w:0]   count;
    logic [rob_depth-1:0] ready;
    opcode_t              op   [rob_depth];
    logic [reg_idx_w-1:0] rd   [rob_depth];
    logic [31:0]          data [rob_depth];

    assign full         = (count == rob_depth);
    assign tail_tag     = tail;
    assign commit_valid = (count != '0) && ready[head] && !halted;
    assign commit_rd    = rd[head];
    assign commit_data  = data[head];
    assign commit_tag   = head;

    always_ff @(posedge clk) begin
        if (rst) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            ready  <= '0;
            halted <= 1'b0;
        end else begin
            if (alloc) begin
                // nop and halt carry no result
                ready[tail] <= (alloc_op == op_nop) || (alloc_op == op_hlt);
                tail        <= tail + 1'b1;
            end
            if (cdb_valid) begin
                ready[cdb_tag] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
                if (op[head] == op_hlt) begin
                    halted <= 1'b1;
                end
            end
            case ({alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            op[tail]   <= alloc_op;
            rd[tail]   <= alloc_rd;
            data[tail] <= '0;
        end
        if (cdb_valid) begin
            data[cdb_tag] <= cdb_data;
        end
    end

    // a same-cycle broadcast counts as a ready operand
    assign rp_ready1 = ready[rp_tag1] || (cdb_valid && cdb_tag == rp_tag1);
    assign rp_ready2 = ready[rp_tag2] || (cdb_valid && cdb_tag == rp_tag2);
    assign rp_data1  = ready[rp_tag1] ? data[rp_tag1] : cdb_data;
    assign rp_data2  = ready[rp_tag2] ? data[rp_tag2] : cdb_data;

endmodule

/* design/reservation_station.sv */
`timescale 1ns/10ps

module reservation_station (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          disp_valid,
    input  ooo_pkg::opcode_t              disp_op,
    input  logic [ooo_pkg::rob_tag_w-1:0] disp_tag,
    input  logic                          q1_busy,
    input  logic [ooo_pkg::rob_tag_w-1:0] q1_tag,
    input  logic [31:0]                   v1,
    input  logic                          q2_busy,
    input  logic [ooo_pkg::rob_tag_w-1:0] q2_tag,
    input  logic [31:0]                   v2,
    input  logic [31:0]                   imm,
    input  logic                          cdb_valid,
    input  logic [ooo_pkg::rob_tag_w-1:0] cdb_tag,
    input  logic [31:0]                   cdb_data,
    output logic                          full,
    output logic                          iss_valid,
    output ooo_pkg::opcode_t              iss_op,
    output logic [ooo_pkg::rob_tag_w-1:0] iss_tag,
    output logic [31:0]                   iss_a,
    output logic [31:0]                   iss_b
);
    import ooo_pkg::*;

    logic [rs_depth-1:0]  busy;
    logic [rs_depth-1:0]  wait1;
    logic [rs_depth-1:0]  wait2;
    logic [rs_depth-1:0]  rdy;
    opcode_t              op    [rs_depth];
    logic [rob_tag_w-1:0] tag   [rs_depth];
    logic [rob_tag_w-1:0] q1    [rs_depth];
    logic [rob_tag_w-1:0] q2    [rs_depth];
    logic [31:0]          val1  [rs_depth];
    logic [31:0]          val2  [rs_depth];
    logic [31:0]          imm_r [rs_depth];
    logic [rs_idx_w-1:0]  free_idx;
    logic [rs_idx_w-1:0]  iss_idx;

    assign full = &busy;
    assign rdy  = busy & ~wait1 & ~wait2;

    // lowest free slot and lowest ready slot
    always_comb begin
        free_idx = '0;
        iss_idx  = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = i[rs_idx_w-1:0];
            end
            if (rdy[i]) begin
                iss_idx = i[rs_idx_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= '0;
            wait1 <= '0;
            wait2 <= '0;
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                if (cdb_valid && wait1[i] && q1[i] == cdb_tag) begin
                    wait1[i] <= 1'b0;
                end
                if (cdb_valid && wait2[i] && q2[i] == cdb_tag) begin
                    wait2[i] <= 1'b0;
                end
            end
            if (iss_valid) begin
                busy[iss_idx] <= 1'b0;
            end
            if (disp_valid) begin
                busy[free_idx]  <= 1'b1;
                wait1[free_idx] <= q1_busy;
                wait2[free_idx] <= q2_busy;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (cdb_valid && wait1[i] && q1[i] == cdb_tag) begin
                val1[i] <= cdb_data;
            end
            if (cdb_valid && wait2[i] && q2[i] == cdb_tag) begin
                val2[i] <= cdb_data;
            end
        end
        if (disp_valid) begin
            op[free_idx]    <= disp_op;
            tag[free_idx]   <= disp_tag;
            q1[free_idx]    <= q1_tag;
            q2[free_idx]    <= q2_tag;
            val1[free_idx]  <= v1;
            val2[free_idx]  <= v2;
            imm_r[free_idx] <= imm;
        end
    end

    assign iss_valid = |rdy;
    assign iss_op    = op[iss_idx];
    assign iss_tag   = tag[iss_idx];
    assign iss_a     = val1[iss_idx];
    // immediate forms take the second operand from the instruction
    assign iss_b = (op[iss_idx] == op_addi || op[iss_idx] == op_sll) ?
                   imm_r[iss_idx] : val2[iss_idx];

endmodule

/* design/ssooo_core.sv */
`timescale 1ns/10ps

module ssooo_core (
    input  logic                          input_clk,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [ooo_pkg::wb_adr_w-1:0]  wb_adr,
    input  logic [31:0]                   wb_dat_w,
    output logic [31:0]                   wb_dat_r,
    output logic                          wb_ack,
    output logic [31:0]                   cycles_consumed,
    output logic                          halted,
    output logic                          commit_valid,
    output logic [ooo_pkg::reg_idx_w-1:0] commit_rd,
    output logic [31:0]                   commit_data
);
    import ooo_pkg::*;

    logic                  run;
    logic [prog_adr_w-1:0] fetch_adr;
    logic [31:0]           fetch_data;

    // decoded instruction
    logic                 iq_valid;
    opcode_t              iq_op;
    logic [reg_idx_w-1:0] iq_rd;
    logic [reg_idx_w-1:0] iq_rs;
    logic [reg_idx_w-1:0] iq_rt;
    logic [31:0]          iq_imm;

    // register status and rob read ports
    logic [31:0]          val1;
    logic [31:0]          val2;
    logic                 busy1;
    logic                 busy2;
    logic [rob_tag_w-1:0] tag1;
    logic [rob_tag_w-1:0] tag2;
    logic                 rp_ready1;
    logic                 rp_ready2;
    logic [31:0]          rp_data1;
    logic [31:0]          rp_data2;
    logic                 rob_full;
    logic                 rs_full;
    logic [rob_tag_w-1:0] tail_tag;
    logic [rob_tag_w-1:0] commit_tag;

    // issue and broadcast
    logic                 iss_valid;
    opcode_t              iss_op;
    logic [rob_tag_w-1:0] iss_tag;
    logic [31:0]          iss_a;
    logic [31:0]          iss_b;
    logic                 cdb_valid;
    logic [rob_tag_w-1:0] cdb_tag;
    logic [31:0]          cdb_data;

    // dispatch
    logic                 is_alu;
    logic                 uses_rt;
    logic                 disp_take;
    logic                 rs_disp;
    logic [reg_idx_w-1:0] alloc_rd;
    logic                 q1_busy;
    logic                 q2_busy;
    logic [31:0]          opnd1;
    logic [31:0]          opnd2;

    assign is_alu    = (iq_op != op_nop) && (iq_op != op_hlt);
    assign uses_rt   = (iq_op != op_addi) && (iq_op != op_sll);
    assign disp_take = iq_valid && !halted && !rob_full && (!is_alu || !rs_full);
    assign rs_disp   = disp_take && is_alu;
    assign alloc_rd  = is_alu ? iq_rd : '0;

    // operand from the register file, else from the rob, else wait on the tag
    assign q1_busy = busy1 && !rp_ready1;
    assign q2_busy = uses_rt && busy2 && !rp_ready2;
    assign opnd1   = busy1 ? rp_data1 : val1;
    assign opnd2   = busy2 ? rp_data2 : val2;

    always_ff @(posedge input_clk) begin
        if (rst) begin
            cycles_consumed <= '0;
        end else if (run && !halted) begin
            cycles_consumed <= cycles_consumed + 1'b1;
        end
    end

    prog_mem_wb u_prog_mem (
        .clk(input_clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .fetch_adr(fetch_adr), .fetch_data(fetch_data),
        .halted(halted), .run(run)
    );

    inst_queue u_inst_queue (
        .clk(input_clk), .rst(rst), .run(run), .halted(halted),
        .fetch_data(fetch_data), .fetch_adr(fetch_adr), .disp_take(disp_take),
        .iq_valid(iq_valid), .iq_op(iq_op), .iq_rd(iq_rd),
        .iq_rs(iq_rs), .iq_rt(iq_rt), .iq_imm(iq_imm)
    );

    reg_status_file u_regs (
        .clk(input_clk), .rst(rst),
        .rd_idx1(iq_rs), .rd_idx2(iq_rt),
        .tag_we(rs_disp), .tag_idx(iq_rd), .tag_val(tail_tag),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_tag(commit_tag), .commit_data(commit_data),
        .val1(val1), .val2(val2), .busy1(busy1), .busy2(busy2),
        .tag1(tag1), .tag2(tag2)
    );

    reorder_buffer u_rob (
        .clk(input_clk), .rst(rst),
        .alloc(disp_take), .alloc_op(iq_op), .alloc_rd(alloc_rd),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .rp_tag1(tag1), .rp_tag2(tag2),
        .full(rob_full), .tail_tag(tail_tag),
        .rp_ready1(rp_ready1), .rp_ready2(rp_ready2),
        .rp_data1(rp_data1), .rp_data2(rp_data2),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_data(commit_data), .commit_tag(commit_tag), .halted(halted)
    );

    reservation_station u_rs (
        .clk(input_clk), .rst(rst),
        .disp_valid(rs_disp), .disp_op(iq_op), .disp_tag(tail_tag),
        .q1_busy(q1_busy), .q1_tag(tag1), .v1(opnd1),
        .q2_busy(q2_busy), .q2_tag(tag2), .v2(opnd2), .imm(iq_imm),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .full(rs_full), .iss_valid(iss_valid), .iss_op(iss_op),
        .iss_tag(iss_tag), .iss_a(iss_a), .iss_b(iss_b)
    );

    alu_unit u_alu (
        .clk(input_clk), .rst(rst),
        .iss_valid(iss_valid), .iss_op(iss_op), .iss_tag(iss_tag),
        .iss_a(iss_a), .iss_b(iss_b),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module ssooo_tb \
    -Mdir obj_dir -o ssooo_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/ssooo_sim > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -qx "Test passed" sim.log && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

/* sources.f */
design/ooo_pkg.sv
design/prog_mem_wb.sv
design/inst_queue.sv
design/reg_status_file.sv
design/reorder_buffer.sv
design/reservation_station.sv
design/alu_unit.sv
design/ssooo_core.sv
verification/clk_gen.sv
verification/ssooo_tb.sv

/* verification/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

/* verification/ssooo_tb.sv */
`timescale 1ns/10ps

module ssooo_tb;
    import ooo_pkg::*;

    localparam int wb_timeout     = 20;
    localparam int commit_timeout = 200;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [8:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [31:0] cycles_consumed;
    logic        halted;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    // program table with the expected commit of each row
    logic [31:0] prog     [64];
    int          exp_rd   [64];
    logic [31:0] exp_data [64];
    int          grp      [64];
    int          n_rows;
    int          halt_row;

    logic [4:0]  got_rd [$];
    logic [31:0] got_data [$];
    int          errors;
    int          grp_err_start;
    int          tests_run;
    int          tests_failed;
    int          ack_count;
    int          accesses;
    bit          aborted;
    int          seed;
    string       test_name [6];

    clk_gen u_clk (.clk(clk));

    ssooo_core uut (
        .input_clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .cycles_consumed(cycles_consumed), .halted(halted),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data)
    );

    // commit stream and ack pulses sampled mid-cycle
    always @(negedge clk) begin
        if (wb_ack) begin
            ack_count++;
        end
        if (commit_valid) begin
            got_rd.push_back(commit_rd);
            got_data.push_back(commit_data);
        end
    end

    function automatic logic [31:0] enc_r(opcode_t op, int rd, int rs, int rt);
        return {op, 2'b00, 5'(rd), 5'(rs), 5'(rt), 11'd0};
    endfunction

    function automatic logic [31:0] enc_i(opcode_t op, int rd, int rs, logic [15:0] imm);
        return {op, 2'b00, 5'(rd), 5'(rs), imm};
    endfunction

    task automatic add_row(input logic [31:0] word, input int rd, input logic [31:0] data,
                           input int g);
        prog[n_rows]     = word;
        exp_rd[n_rows]   = rd;
        exp_data[n_rows] = data;
        grp[n_rows]      = g;
        n_rows++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input int g);
        tests_run++;
        if (errors != grp_err_start) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", g + 1, test_name[g],
                 (errors == grp_err_start) ? "ok" : "errors");
        grp_err_start = errors;
    endtask

    // one classic cycle held until ack
    task automatic wb_access(input logic we, input logic [8:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata);
        int n;
        n = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge clk);
        while (!wb_ack && n < wb_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            $display("wishbone access to address 0x%h got no ack", adr);
            errors++;
            aborted = 1'b1;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        accesses++;
    endtask

    task automatic wait_commit(output bit ok);
        int n;
        n = 0;
        while (got_rd.size() == 0 && n < commit_timeout) begin
            @(posedge clk);
            n++;
        end
        ok = (got_rd.size() != 0);
    endtask

    initial begin
        logic [15:0] rnd_imm;
        logic [31:0] rnd_val;
        logic [31:0] rdata;
        logic [31:0] cyc_a;
        logic [4:0]  c_rd;
        logic [31:0] c_data;
        int          sum;
        bit          ok;

        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        seed     = 47755;
        errors   = 0;
        aborted  = 1'b0;
        n_rows   = 0;
        sum      = 0;
        test_name = '{"alu ops", "dependent chain", "long chain", "r0 write", "halt",
                      "ctrl read"};

        rnd_imm = 16'($random(seed));
        rnd_val = {{16{rnd_imm[15]}}, rnd_imm};
        // r1 = 12, r2 = -3, r3 = random, then every alu op on r1 and r2
        add_row(enc_i(op_addi, 1, 0, 16'd12), 1, 32'd12, 0);
        add_row(enc_i(op_addi, 2, 0, 16'hfffd), 2, 32'hffff_fffd, 0);
        add_row(enc_i(op_addi, 3, 0, rnd_imm), 3, rnd_val, 0);
        add_row(enc_r(op_add, 4, 1, 2), 4, 32'd9, 0);
        add_row(enc_r(op_sub, 5, 1, 2), 5, 32'd15, 0);
        add_row(enc_r(op_and, 6, 1, 2), 6, 32'd12, 0);
        add_row(enc_r(op_or, 7, 1, 2), 7, 32'hffff_fffd, 0);
        add_row(enc_r(op_xor, 8, 1, 2), 8, 32'hffff_fff1, 0);
        add_row(enc_r(op_slt, 9, 2, 1), 9, 32'd1, 0);
        add_row(enc_r(op_slt, 10, 1, 2), 10, 32'd0, 0);
        add_row(enc_i(op_sll, 11, 1, 16'd4), 11, 32'hc0, 0);
        add_row(enc_r(op_add, 12, 3, 1), 12, rnd_val + 32'd12, 1);
        add_row(enc_r(op_sub, 13, 12, 3), 13, 32'd12, 1);
        add_row(enc_r(op_add, 18, 12, 13), 18, rnd_val + 32'd24, 1);
        add_row(enc_i(op_sll, 19, 18, 16'd1), 19, (rnd_val + 32'd24) << 1, 1);
        // running sum in r14 over more rows than the station and the rob hold
        for (int k = 1; k <= 12; k++) begin
            sum += k;
            add_row(enc_i(op_addi, 14, 14, 16'(k)), 14, 32'(sum), 2);
        end
        add_row(enc_i(op_addi, 0, 0, 16'h55), 0, 32'h55, 3);
        add_row(enc_r(op_add, 15, 0, 1), 15, 32'd12, 3);
        halt_row = n_rows;
        add_row({op_hlt, 28'd0}, 0, 32'd0, 4);
        add_row(enc_i(op_addi, 16, 0, 16'd1), 16, 32'd1, 4);
        add_row(enc_i(op_addi, 17, 0, 16'd2), 17, 32'd2, 4);

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        ack_count     = 0;
        accesses      = 0;
        grp_err_start = errors;
        check_value("halted", 32'(halted), 32'd0);
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        check_value("wb_ack", 32'(wb_ack), 32'd0);
        check_value("cycles_consumed", cycles_consumed, 32'd0);

        for (int i = 0; i < n_rows && !aborted; i++) begin
            wb_access(1'b1, 9'(i), prog[i], rdata);
        end
        if (!aborted) begin
            wb_access(1'b1, ctrl_adr, 32'd1, rdata);
        end

        for (int i = 0; i <= halt_row && !aborted; i++) begin
            wait_commit(ok);
            if (!ok) begin
                $display("no commit arrived for row %0d before the timeout", i);
                errors++;
                aborted = 1'b1;
            end else begin
                c_rd   = got_rd.pop_front();
                c_data = got_data.pop_front();
                check_value($sformatf("commit_rd row %0d", i), 32'(c_rd), 32'(exp_rd[i]));
                if (i != halt_row) begin
                    check_value($sformatf("commit_data row %0d", i), c_data, exp_data[i]);
                end
                if (i < halt_row && grp[i + 1] != grp[i]) begin
                    report_test(grp[i]);
                end
            end
        end

        if (!aborted) begin
            @(negedge clk);
            check_value("halted", 32'(halted), 32'd1);
            cyc_a = cycles_consumed;
            // observation window after the halt
            repeat (16) @(negedge clk);
            check_value("cycles_consumed", cycles_consumed, cyc_a);
            if (cyc_a == 32'd0) begin
                $display("cycles_consumed stayed at zero through the run");
                errors++;
            end
            if (got_rd.size() != 0) begin
                $display("%0d commits appeared after the halt", got_rd.size());
                errors++;
            end
            report_test(4);
            wb_access(1'b0, ctrl_adr, 32'd0, rdata);
            check_value("wb_dat_r", {31'd0, rdata[0]}, 32'd1);
            @(negedge clk);
            check_value("wb_ack", 32'(wb_ack), 32'd0);
            check_value("wb_ack count", 32'(ack_count), 32'(accesses));
            report_test(5);
        end

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
